// File: hw/robPkg.sv
// shared widths and encodings; tags are 1-based and tag 0 never names an entry
package robPkg;

    // buffer geometry
    localparam int ROB_SIZE_BITS = 3;
    localparam int ROB_SIZE = 1 << ROB_SIZE_BITS;
    localparam int TAG_W = ROB_SIZE_BITS + 1;  // one extra bit so tag ROB_SIZE fits

    // field widths
    localparam int OPC_W = 12;
    localparam int DATA_W = 32;
    localparam int RD_W = 5;
    localparam int CDB_PORTS = 4;

    // opcode encodings, {major, funct} in six bits each
    localparam logic [OPC_W-1:0] opAdd = 12'h020;
    localparam logic [OPC_W-1:0] opLw = 12'h8C0;
    localparam logic [OPC_W-1:0] opSw = 12'hAC0;
    localparam logic [OPC_W-1:0] opBeq = 12'h100;
    localparam logic [OPC_W-1:0] opBne = 12'h140;
    localparam logic [OPC_W-1:0] opJ = 12'h080;
    localparam logic [OPC_W-1:0] opJal = 12'h0C0;
    localparam logic [OPC_W-1:0] opJr = 12'h008;
    localparam logic [OPC_W-1:0] opHlt = 12'hFC0;

    // commitCtrl word
    localparam int CTRL_W = 3;
    localparam int CTRL_REGWRITE = 2;
    localparam int CTRL_MEMREAD = 1;
    localparam int CTRL_MEMWRITE = 0;

    // pointer step, wraps from ROB_SIZE back to 1
    function automatic logic [TAG_W-1:0] nextTag(input logic [TAG_W-1:0] tag);
        logic [TAG_W-1:0] result;
        if (tag == TAG_W'(ROB_SIZE)) begin
            result = TAG_W'(1);
        end else begin
            result = tag + 1'b1;
        end
        return result;
    endfunction

endpackage

// File: hw/robAllocator.sv
// tail pointer and full flag; fullFlag may stay high one cycle longer than needed near a retire
module robAllocator (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     validInst,
    input  logic                     flush,
    input  logic                     headBusy,
    input  logic [robPkg::TAG_W-1:0] headTag,
    output logic                     fullFlag,
    output logic                     allocEn,
    output logic [robPkg::TAG_W-1:0] allocTag
);
    import robPkg::*;

    logic [TAG_W-1:0] tailTag;
    logic [TAG_W-1:0] tailNext;
    logic fullNow;     // every slot busy right now
    logic fillsUp;     // this dispatch takes the last free slot

    assign allocEn = validInst & ~fullFlag;  // dropped while full, producer retries
    assign allocTag = tailTag;
    assign tailNext = nextTag(tailTag);

    assign fullNow = (tailTag == headTag) & headBusy;
    assign fillsUp = allocEn & (tailNext == headTag);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tailTag <= TAG_W'(1);
        end else if (flush) begin
            tailTag <= TAG_W'(1);
        end else if (allocEn) begin
            tailTag <= tailNext;
        end
    end

    // registered, but looks one dispatch ahead so a back-to-back
    // dispatch can never land on a busy slot
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fullFlag <= 1'b0;
        end else begin
            fullFlag <= ~flush & (fullNow | fillsUp);
        end
    end

endmodule

// File: hw/robEntryTable.sv
// entry storage; a CDB write to a free slot is ignored, same-tag CDB writes go to the higher port
module robEntryTable (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      allocEn,
    input  logic                      retire,
    input  logic                      flush,
    input  logic [robPkg::TAG_W-1:0]  allocTag,
    input  logic [robPkg::TAG_W-1:0]  headTag,
    input  logic [robPkg::OPC_W-1:0]  decOpcode,
    input  logic [robPkg::DATA_W-1:0] decPc,
    input  logic [robPkg::RD_W-1:0]   decRd,
    input  logic                      decPrediction,
    input  logic [robPkg::DATA_W-1:0] branchTarget,
    input  logic [robPkg::DATA_W-1:0] initData,
    input  logic [robPkg::TAG_W-1:0]  cdbTag1,
    input  logic [robPkg::TAG_W-1:0]  cdbTag2,
    input  logic [robPkg::TAG_W-1:0]  cdbTag3,
    input  logic [robPkg::TAG_W-1:0]  cdbTag4,
    input  logic [robPkg::DATA_W-1:0] cdbData1,
    input  logic [robPkg::DATA_W-1:0] cdbData2,
    input  logic [robPkg::DATA_W-1:0] cdbData3,
    input  logic [robPkg::DATA_W-1:0] cdbData4,
    input  logic                      cdbExcept1,
    input  logic                      cdbExcept2,
    input  logic                      cdbExcept3,
    input  logic                      cdbExcept4,
    input  logic                      cdbDecision1,
    input  logic                      cdbDecision3,
    input  logic                      cdbDecision4,
    input  logic [robPkg::TAG_W-1:0]  rpTag1,
    input  logic [robPkg::TAG_W-1:0]  rpTag2,
    output logic [robPkg::DATA_W-1:0] rpData1,
    output logic [robPkg::DATA_W-1:0] rpData2,
    output logic                      rpReady1,
    output logic                      rpReady2,
    output logic                      headBusy,
    output logic                      headReady,
    output logic                      headBranch,
    output logic                      headMispredict,
    output logic                      headExcept,
    output logic [robPkg::OPC_W-1:0]  headOpcode,
    output logic [robPkg::DATA_W-1:0] headPc,
    output logic [robPkg::RD_W-1:0]   headRd,
    output logic [robPkg::DATA_W-1:0] headData,
    output logic [robPkg::DATA_W-1:0] headBta
);
    import robPkg::*;

    // tag t lives in slot t-1, tag ROB_SIZE wraps onto the top slot
    function automatic logic [ROB_SIZE_BITS-1:0] slotOf(input logic [TAG_W-1:0] tag);
        logic [TAG_W-1:0] idx;
        idx = tag - 1'b1;
        return idx[ROB_SIZE_BITS-1:0];
    endfunction

    // per-entry control state
    logic [ROB_SIZE-1:0] busy;
    logic [ROB_SIZE-1:0] ready;
    logic [ROB_SIZE-1:0] excepted;
    logic [ROB_SIZE-1:0] isBranch;   // still set once ready means mispredicted
    logic [ROB_SIZE-1:0] predTaken;

    // per-entry payload
    logic [OPC_W-1:0]  opcode [ROB_SIZE];
    logic [DATA_W-1:0] pc [ROB_SIZE];
    logic [RD_W-1:0]   rd [ROB_SIZE];
    logic [DATA_W-1:0] data [ROB_SIZE];
    logic [DATA_W-1:0] bta [ROB_SIZE];

    logic [ROB_SIZE_BITS-1:0] allocSlot;
    logic [ROB_SIZE_BITS-1:0] headSlot;
    logic readyAtDispatch;
    logic branchAtDispatch;

    // CDB ports gathered so one loop handles all of them
    logic [TAG_W-1:0]         cdbTag [CDB_PORTS];
    logic [DATA_W-1:0]        cdbData [CDB_PORTS];
    logic                     cdbExcept [CDB_PORTS];
    logic                     cdbDecision [CDB_PORTS];
    logic [ROB_SIZE_BITS-1:0] cdbSlot [CDB_PORTS];
    logic                     cdbActive [CDB_PORTS];

    assign cdbTag = '{cdbTag1, cdbTag2, cdbTag3, cdbTag4};
    assign cdbData = '{cdbData1, cdbData2, cdbData3, cdbData4};
    assign cdbExcept = '{cdbExcept1, cdbExcept2, cdbExcept3, cdbExcept4};
    assign cdbDecision = '{cdbDecision1, 1'b0, cdbDecision3, cdbDecision4};  // port 2 has none

    always_comb begin
        for (int p = 0; p < CDB_PORTS; p++) begin
            cdbSlot[p] = slotOf(cdbTag[p]);
            cdbActive[p] = (cdbTag[p] != '0) && busy[cdbSlot[p]];
        end
    end

    assign allocSlot = slotOf(allocTag);
    assign headSlot = slotOf(headTag);
    assign readyAtDispatch = (decOpcode == opHlt) || (decOpcode == opJal);
    assign branchAtDispatch = (decOpcode == opBeq) || (decOpcode == opBne);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= '0;
            ready <= '0;
            excepted <= '0;
            isBranch <= '0;
            predTaken <= '0;
        end else if (flush) begin
            busy <= '0;  // whole table dropped, dispatch in this cycle too
        end else begin
            if (allocEn) begin
                busy[allocSlot] <= 1'b1;
                ready[allocSlot] <= readyAtDispatch;
                excepted[allocSlot] <= 1'b0;
                isBranch[allocSlot] <= branchAtDispatch;
                predTaken[allocSlot] <= decPrediction;
            end
            // later ports overwrite earlier ones on the same tag
            for (int p = 0; p < CDB_PORTS; p++) begin
                if (cdbActive[p]) begin
                    ready[cdbSlot[p]] <= 1'b1;
                    excepted[cdbSlot[p]] <= cdbExcept[p];
                    if (p == 1) begin
                        isBranch[cdbSlot[p]] <= 1'b0;
                    end else begin
                        isBranch[cdbSlot[p]] <= isBranch[cdbSlot[p]]
                            & (cdbDecision[p] ^ predTaken[cdbSlot[p]]);
                    end
                end
            end
            if (retire) begin
                busy[headSlot] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (allocEn) begin
            opcode[allocSlot] <= decOpcode;
            pc[allocSlot] <= decPc;
            rd[allocSlot] <= decRd;
            bta[allocSlot] <= branchTarget;
            data[allocSlot] <= initData;  // final value for jal
        end
        for (int p = 0; p < CDB_PORTS; p++) begin
            if (cdbActive[p]) begin
                data[cdbSlot[p]] <= cdbData[p];
            end
        end
    end

    // head view for the commit unit
    assign headBusy = busy[headSlot];
    assign headReady = ready[headSlot];
    assign headBranch = isBranch[headSlot];
    assign headMispredict = isBranch[headSlot] & ready[headSlot];
    assign headExcept = excepted[headSlot];
    assign headOpcode = opcode[headSlot];
    assign headPc = pc[headSlot];
    assign headRd = rd[headSlot];
    assign headData = data[headSlot];
    assign headBta = bta[headSlot];

    // operand reads, same cycle
    assign rpData1 = data[slotOf(rpTag1)];
    assign rpReady1 = ready[slotOf(rpTag1)];
    assign rpData2 = data[slotOf(rpTag2)];
    assign rpReady2 = ready[slotOf(rpTag2)];

endmodule

// File: hw/robCommit.sv
// in-order retire, one per cycle; nothing retires in the cycle flushFlag is high
module robCommit (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      headBusy,
    input  logic                      headReady,
    input  logic                      headBranch,
    input  logic                      headMispredict,
    input  logic                      headExcept,
    input  logic [robPkg::OPC_W-1:0]  headOpcode,
    input  logic [robPkg::DATA_W-1:0] headPc,
    input  logic [robPkg::RD_W-1:0]   headRd,
    input  logic [robPkg::DATA_W-1:0] headData,
    input  logic [robPkg::DATA_W-1:0] headBta,
    output logic [robPkg::TAG_W-1:0]  headTag,
    output logic                      retire,
    output logic                      flushFlag,
    output logic                      wrongPrediction,
    output logic                      exceptionFlag,
    output logic [robPkg::OPC_W-1:0]  commitOpcode,
    output logic [robPkg::DATA_W-1:0] commitPc,
    output logic [robPkg::RD_W-1:0]   commitRd,
    output logic [robPkg::DATA_W-1:0] commitData,
    output logic [robPkg::CTRL_W-1:0] commitCtrl,
    output logic [robPkg::DATA_W-1:0] commitBta
);
    import robPkg::*;

    logic headLive;       // busy bits are stale while the flush is applied
    logic doMispredict;
    logic doExcept;
    logic flushReq;

    function automatic logic [CTRL_W-1:0] ctrlOf(input logic [OPC_W-1:0] opc);
        logic [CTRL_W-1:0] ctrl;
        ctrl = '0;
        ctrl[CTRL_REGWRITE] = !(opc == opJr || opc == opSw || opc == opBeq
                                || opc == opBne || opc == opJ);
        ctrl[CTRL_MEMREAD] = (opc == opLw);
        ctrl[CTRL_MEMWRITE] = (opc == opSw);
        return ctrl;
    endfunction

    assign headLive = headBusy & ~flushFlag;

    // a finished branch whose flag survived was predicted wrong
    assign retire = headLive & headReady & ~headBranch & ~headExcept;
    assign doMispredict = headLive & headMispredict;
    assign doExcept = headLive & headExcept & ~doMispredict;  // no ready needed
    assign flushReq = doMispredict | doExcept;

    assign exceptionFlag = headLive & headExcept;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            headTag <= TAG_W'(1);
        end else if (flushReq) begin
            headTag <= TAG_W'(1);
        end else if (retire) begin
            headTag <= nextTag(headTag);
        end
    end

    // commit outputs live for one cycle only, zero otherwise
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flushFlag <= 1'b0;
            wrongPrediction <= 1'b0;
            commitOpcode <= '0;
            commitPc <= '0;
            commitRd <= '0;
            commitData <= '0;
            commitCtrl <= '0;
            commitBta <= '0;
        end else begin
            flushFlag <= flushReq;
            wrongPrediction <= doMispredict;
            commitOpcode <= '0;
            commitPc <= '0;
            commitRd <= '0;
            commitData <= '0;
            commitCtrl <= '0;
            commitBta <= '0;
            if (retire) begin
                commitOpcode <= headOpcode;
                commitPc <= headPc;
                commitRd <= headRd;
                commitData <= headData;
                commitCtrl <= ctrlOf(headOpcode);
            end else if (doMispredict) begin
                commitOpcode <= headOpcode;
                commitBta <= headBta;  // fetch restarts here
            end else if (doExcept) begin
                commitOpcode <= headOpcode;
                commitPc <= headPc;    // faulting pc
            end
        end
    end

endmodule

// File: hw/reorderBuffer.sv
// reorder buffer top; a nonzero commitOpcode marks a commit, and the table empties on flushFlag
module reorderBuffer (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      validInst,
    input  logic [robPkg::OPC_W-1:0]  decOpcode,
    input  logic [robPkg::DATA_W-1:0] decPc,
    input  logic [robPkg::RD_W-1:0]   decRd,
    input  logic                      decPrediction,
    input  logic [robPkg::DATA_W-1:0] branchTarget,
    input  logic [robPkg::DATA_W-1:0] initData,
    input  logic [robPkg::TAG_W-1:0]  cdbTag1,
    input  logic [robPkg::TAG_W-1:0]  cdbTag2,
    input  logic [robPkg::TAG_W-1:0]  cdbTag3,
    input  logic [robPkg::TAG_W-1:0]  cdbTag4,
    input  logic [robPkg::DATA_W-1:0] cdbData1,
    input  logic [robPkg::DATA_W-1:0] cdbData2,
    input  logic [robPkg::DATA_W-1:0] cdbData3,
    input  logic [robPkg::DATA_W-1:0] cdbData4,
    input  logic                      cdbExcept1,
    input  logic                      cdbExcept2,
    input  logic                      cdbExcept3,
    input  logic                      cdbExcept4,
    input  logic                      cdbDecision1,
    input  logic                      cdbDecision3,
    input  logic                      cdbDecision4,
    input  logic [robPkg::TAG_W-1:0]  rpTag1,
    input  logic [robPkg::TAG_W-1:0]  rpTag2,
    output logic [robPkg::DATA_W-1:0] rpData1,
    output logic [robPkg::DATA_W-1:0] rpData2,
    output logic                      rpReady1,
    output logic                      rpReady2,
    output logic                      fullFlag,
    output logic                      exceptionFlag,
    output logic                      flushFlag,
    output logic                      wrongPrediction,
    output logic [robPkg::OPC_W-1:0]  commitOpcode,
    output logic [robPkg::DATA_W-1:0] commitPc,
    output logic [robPkg::RD_W-1:0]   commitRd,
    output logic [robPkg::DATA_W-1:0] commitData,
    output logic [robPkg::CTRL_W-1:0] commitCtrl,
    output logic [robPkg::DATA_W-1:0] commitBta
);
    import robPkg::*;

    logic allocEn;
    logic retire;
    logic [TAG_W-1:0] allocTag;
    logic [TAG_W-1:0] headTag;

    // head-entry view
    logic headBusy, headReady, headBranch, headMispredict, headExcept;
    logic [OPC_W-1:0]  headOpcode;
    logic [DATA_W-1:0] headPc;
    logic [RD_W-1:0]   headRd;
    logic [DATA_W-1:0] headData;
    logic [DATA_W-1:0] headBta;

    robAllocator alloc0 (
        .clk(clk), .rst(rst), .validInst(validInst), .flush(flushFlag),
        .headBusy(headBusy), .headTag(headTag),
        .fullFlag(fullFlag), .allocEn(allocEn), .allocTag(allocTag)
    );

    robEntryTable table0 (
        .clk(clk), .rst(rst), .allocEn(allocEn), .retire(retire), .flush(flushFlag),
        .allocTag(allocTag), .headTag(headTag),
        .decOpcode(decOpcode), .decPc(decPc), .decRd(decRd),
        .decPrediction(decPrediction), .branchTarget(branchTarget), .initData(initData),
        .cdbTag1(cdbTag1), .cdbTag2(cdbTag2), .cdbTag3(cdbTag3), .cdbTag4(cdbTag4),
        .cdbData1(cdbData1), .cdbData2(cdbData2), .cdbData3(cdbData3), .cdbData4(cdbData4),
        .cdbExcept1(cdbExcept1), .cdbExcept2(cdbExcept2),
        .cdbExcept3(cdbExcept3), .cdbExcept4(cdbExcept4),
        .cdbDecision1(cdbDecision1), .cdbDecision3(cdbDecision3),
        .cdbDecision4(cdbDecision4),
        .rpTag1(rpTag1), .rpTag2(rpTag2),
        .rpData1(rpData1), .rpData2(rpData2), .rpReady1(rpReady1), .rpReady2(rpReady2),
        .headBusy(headBusy), .headReady(headReady), .headBranch(headBranch),
        .headMispredict(headMispredict), .headExcept(headExcept),
        .headOpcode(headOpcode), .headPc(headPc), .headRd(headRd),
        .headData(headData), .headBta(headBta)
    );

    robCommit commit0 (
        .clk(clk), .rst(rst),
        .headBusy(headBusy), .headReady(headReady), .headBranch(headBranch),
        .headMispredict(headMispredict), .headExcept(headExcept),
        .headOpcode(headOpcode), .headPc(headPc), .headRd(headRd),
        .headData(headData), .headBta(headBta),
        .headTag(headTag), .retire(retire),
        .flushFlag(flushFlag), .wrongPrediction(wrongPrediction),
        .exceptionFlag(exceptionFlag),
        .commitOpcode(commitOpcode), .commitPc(commitPc), .commitRd(commitRd),
        .commitData(commitData), .commitCtrl(commitCtrl), .commitBta(commitBta)
    );

endmodule

// File: verif/robTests.svh
// directed tests; each test leaves the buffer empty, commits are sampled on the falling edge
`ifndef ROB_TESTS_SVH
`define ROB_TESTS_SVH

    // scoreboard, program order of live tags and what each should commit
    logic [TAG_W-1:0] order[$];
    logic [TAG_W-1:0] modelTail = TAG_W'(1);
    logic [OPC_W-1:0] expOpc [1:ROB_SIZE];
    logic [DATA_W-1:0] expPc [1:ROB_SIZE];
    logic [RD_W-1:0] expRd [1:ROB_SIZE];
    logic [DATA_W-1:0] expData [1:ROB_SIZE];
    logic [CTRL_W-1:0] expCtrl [1:ROB_SIZE];

    task automatic initInputs();
        validInst <= 1'b0;
        decOpcode <= '0;
        decPc <= '0;
        decRd <= '0;
        decPrediction <= 1'b0;
        branchTarget <= '0;
        initData <= '0;
        {cdbTag1, cdbTag2, cdbTag3, cdbTag4} <= '0;
        {cdbData1, cdbData2, cdbData3, cdbData4} <= '0;
        {cdbExcept1, cdbExcept2, cdbExcept3, cdbExcept4} <= '0;
        {cdbDecision1, cdbDecision3, cdbDecision4} <= '0;
        rpTag1 <= '0;
        rpTag2 <= '0;
    endtask

    task automatic dispatch(input logic [OPC_W-1:0] opc, input logic [DATA_W-1:0] pc,
                            input logic [RD_W-1:0] rd, input logic pred,
                            input logic [DATA_W-1:0] bta, input logic [DATA_W-1:0] init,
                            input logic [CTRL_W-1:0] ctrl, output logic accepted);
        @(posedge clk);
        validInst <= 1'b1;
        decOpcode <= opc;
        decPc <= pc;
        decRd <= rd;
        decPrediction <= pred;
        branchTarget <= bta;
        initData <= init;
        @(negedge clk);
        accepted = !fullFlag;  // full is registered, so this is what the edge sees
        @(posedge clk);
        validInst <= 1'b0;
        if (accepted) begin
            order.push_back(modelTail);
            expOpc[modelTail] = opc;
            expPc[modelTail] = pc;
            expRd[modelTail] = rd;
            expData[modelTail] = init;
            expCtrl[modelTail] = ctrl;
            modelTail = (modelTail == TAG_W'(ROB_SIZE)) ? TAG_W'(1) : modelTail + TAG_W'(1);
        end
    endtask

    task automatic cdbWrite(input int port, input logic [TAG_W-1:0] tag,
                            input logic [DATA_W-1:0] value, input logic exc, input logic taken);
        @(posedge clk);
        case (port)
            1: begin
                cdbTag1 <= tag;
                cdbData1 <= value;
                cdbExcept1 <= exc;
                cdbDecision1 <= taken;
            end
            2: begin
                cdbTag2 <= tag;
                cdbData2 <= value;
                cdbExcept2 <= exc;
            end
            3: begin
                cdbTag3 <= tag;
                cdbData3 <= value;
                cdbExcept3 <= exc;
                cdbDecision3 <= taken;
            end
            default: begin
                cdbTag4 <= tag;
                cdbData4 <= value;
                cdbExcept4 <= exc;
                cdbDecision4 <= taken;
            end
        endcase
        expData[tag] = value;
        @(posedge clk);
        {cdbTag1, cdbTag2, cdbTag3, cdbTag4} <= '0;
        {cdbExcept1, cdbExcept2, cdbExcept3, cdbExcept4} <= '0;
    endtask

    task automatic expectCommit();
        logic [TAG_W-1:0] t;
        int waited;
        t = order.pop_front();
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (commitOpcode == '0 && waited < 20);
        if (commitOpcode == '0) begin
            $display("no commit appeared for tag %0d", t);
            $display("tests failed");
            $fatal(1);
        end
        checkOpcode("commitOpcode", commitOpcode, expOpc[t]);
        checkData("commitPc", commitPc, expPc[t]);
        checkData("commitRd", DATA_W'(commitRd), DATA_W'(expRd[t]));
        checkData("commitData", commitData, expData[t]);
        checkData("commitCtrl", DATA_W'(commitCtrl), DATA_W'(expCtrl[t]));
    endtask

    task automatic waitFlush();
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!flushFlag && waited < 20);
        if (!flushFlag) begin
            $display("flushFlag never rose");
            $display("tests failed");
            $fatal(1);
        end
        order.delete();
        modelTail = TAG_W'(1);  // table empties on the flush
    endtask

    task automatic drain();
        int port;
        port = 1;
        while (order.size() > 0) begin
            cdbWrite(port, order[0], $urandom, 1'b0, 1'b0);
            expectCommit();
            port = (port % 4) + 1;
        end
    endtask

    task automatic inOrderRetire();
        logic ok;
        for (int i = 0; i < 5; i++) begin
            dispatch(opAdd, DATA_W'(32'h100 + 4 * i), RD_W'(i + 1), 1'b0, '0, '0, 3'b100, ok);
        end
        for (int i = 4; i >= 0; i--) begin
            cdbWrite((i % 4) + 1, order[i], $urandom, 1'b0, 1'b0);
        end
        repeat (5) expectCommit();
    endtask

    task automatic fullAndBackPressure();
        logic ok;
        int waited;
        for (int i = 0; i < ROB_SIZE; i++) begin
            dispatch(opAdd, DATA_W'(32'h200 + 4 * i), RD_W'(i + 2), 1'b0, '0, '0, 3'b100, ok);
            checkBit("accepted", ok, 1'b1);
        end
        @(negedge clk);
        checkBit("fullFlag", fullFlag, 1'b1);
        dispatch(opAdd, 32'h300, 5'd9, 1'b0, '0, '0, 3'b100, ok);
        checkBit("accepted while full", ok, 1'b0);
        cdbWrite(2, order[0], $urandom, 1'b0, 1'b0);
        expectCommit();
        waited = 0;
        while (fullFlag && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        checkBit("fullFlag", fullFlag, 1'b0);
        dispatch(opAdd, 32'h300, 5'd9, 1'b0, '0, '0, 3'b100, ok);
        checkBit("accepted after retire", ok, 1'b1);
        drain();
    endtask

    task automatic branchOutcomes();
        logic ok;
        dispatch(opBeq, 32'h400, '0, 1'b0, 32'h480, '0, 3'b000, ok);
        cdbWrite(1, order[0], $urandom, 1'b0, 1'b0);
        expectCommit();
        dispatch(opBeq, 32'h404, '0, 1'b1, 32'h4C0, '0, 3'b000, ok);
        dispatch(opAdd, 32'h408, 5'd3, 1'b0, '0, '0, 3'b100, ok);
        dispatch(opAdd, 32'h40C, 5'd4, 1'b0, '0, '0, 3'b100, ok);
        cdbWrite(2, order[1], $urandom, 1'b0, 1'b0);
        cdbWrite(4, order[2], $urandom, 1'b0, 1'b0);
        cdbWrite(3, order[0], $urandom, 1'b0, 1'b0);  // not taken against a taken guess
        waitFlush();
        checkBit("wrongPrediction", wrongPrediction, 1'b1);
        checkOpcode("commitOpcode", commitOpcode, opBeq);
        checkData("commitBta", commitBta, 32'h4C0);
        repeat (5) begin
            @(negedge clk);
            checkOpcode("commitOpcode after flush", commitOpcode, '0);
        end
        dispatch(opJal, 32'h4C0, 5'd31, 1'b0, '0, 32'h4C4, 3'b100, ok);
        rpTag1 <= TAG_W'(1);  // first dispatch after a flush lands on tag 1
        @(negedge clk);
        checkBit("rpReady1", rpReady1, 1'b1);
        checkData("rpData1", rpData1, 32'h4C4);
        expectCommit();
    endtask

    task automatic exceptionFlush();
        logic ok;
        dispatch(opLw, 32'h500, 5'd6, 1'b0, '0, '0, 3'b110, ok);
        cdbWrite(2, order[0], $urandom, 1'b1, 1'b0);
        @(negedge clk);
        checkBit("exceptionFlag", exceptionFlag, 1'b1);
        checkBit("flushFlag", flushFlag, 1'b0);
        waitFlush();
        checkBit("wrongPrediction", wrongPrediction, 1'b0);
        checkOpcode("commitOpcode", commitOpcode, opLw);
        checkData("commitPc", commitPc, 32'h500);
        repeat (2) @(negedge clk);
    endtask

    task automatic operandRead();
        logic ok;
        logic [DATA_W-1:0] v1;
        logic [DATA_W-1:0] v2;
        v1 = $urandom;
        v2 = $urandom;
        dispatch(opAdd, 32'h600, 5'd7, 1'b0, '0, '0, 3'b100, ok);
        dispatch(opAdd, 32'h604, 5'd8, 1'b0, '0, '0, 3'b100, ok);
        rpTag1 <= order[0];
        rpTag2 <= order[1];
        @(negedge clk);
        checkBit("rpReady1", rpReady1, 1'b0);
        checkBit("rpReady2", rpReady2, 1'b0);
        cdbWrite(3, order[1], v2, 1'b0, 1'b0);  // younger first, nothing retires yet
        @(negedge clk);
        checkBit("rpReady2", rpReady2, 1'b1);
        checkData("rpData2", rpData2, v2);
        checkBit("rpReady1", rpReady1, 1'b0);
        cdbWrite(4, order[0], v1, 1'b0, 1'b0);
        @(negedge clk);
        checkBit("rpReady1", rpReady1, 1'b1);
        checkData("rpData1", rpData1, v1);
        repeat (2) expectCommit();
    endtask

    task automatic readyAtDispatch();
        logic ok;
        dispatch(opJal, 32'h700, 5'd31, 1'b0, '0, 32'h704, 3'b100, ok);
        expectCommit();
        dispatch(opHlt, 32'h704, '0, 1'b0, '0, 32'h0, 3'b100, ok);
        expectCommit();
        dispatch(opSw, 32'h708, '0, 1'b0, '0, '0, 3'b001, ok);
        cdbWrite(1, order[0], $urandom, 1'b0, 1'b0);
        expectCommit();
        dispatch(opLw, 32'h70C, 5'd10, 1'b0, '0, '0, 3'b110, ok);
        cdbWrite(3, order[0], $urandom, 1'b0, 1'b0);
        expectCommit();
    endtask

`endif

// File: verif/robTb.sv
// directed testbench for the reorder buffer; expects an empty buffer after reset and one commit per cycle
module robTb;
    import robPkg::*;

    localparam int TEST_STEPS = 80;  // rough count of dispatch, write and commit steps

    logic clk;
    logic rst;
    logic validInst;
    logic [OPC_W-1:0] decOpcode;
    logic [DATA_W-1:0] decPc;
    logic [RD_W-1:0] decRd;
    logic decPrediction;
    logic [DATA_W-1:0] branchTarget;
    logic [DATA_W-1:0] initData;
    logic [TAG_W-1:0] cdbTag1, cdbTag2, cdbTag3, cdbTag4;
    logic [DATA_W-1:0] cdbData1, cdbData2, cdbData3, cdbData4;
    logic cdbExcept1, cdbExcept2, cdbExcept3, cdbExcept4;
    logic cdbDecision1, cdbDecision3, cdbDecision4;
    logic [TAG_W-1:0] rpTag1, rpTag2;
    logic [DATA_W-1:0] rpData1, rpData2;
    logic rpReady1, rpReady2;
    logic fullFlag, exceptionFlag, flushFlag, wrongPrediction;
    logic [OPC_W-1:0] commitOpcode;
    logic [DATA_W-1:0] commitPc;
    logic [RD_W-1:0] commitRd;
    logic [DATA_W-1:0] commitData;
    logic [CTRL_W-1:0] commitCtrl;
    logic [DATA_W-1:0] commitBta;

    reorderBuffer dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic checkData(input string name, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    task automatic checkOpcode(input string name, input logic [OPC_W-1:0] got,
                               input logic [OPC_W-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    `include "robTests.svh"

    initial begin
        #(TEST_STEPS * 40 * 4);
        $display("watchdog expired before the test sequence finished");
        $display("tests failed");
        $fatal(1);
    end

    initial begin
        void'($urandom(12));
        initInputs();
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        inOrderRetire();
        fullAndBackPressure();
        branchOutcomes();
        exceptionFlush();
        operandRead();
        readyAtDispatch();
        $display("all tests passed");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+verif
hw/robPkg.sv
hw/robAllocator.sv
hw/robEntryTable.sv
hw/robCommit.sv
hw/reorderBuffer.sv
verif/robTb.sv

// File: run.sh
#!/bin/bash
# build and run the reorder buffer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module robTb -f filelist.f -Mdir obj_dir > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/VrobTb > sim.log 2>&1

grep -q "tests failed" sim.log && { echo "simulation FAILED, see sim.log"; exit 1; }
grep -q "all tests passed" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
